/* tb/tamagotchi_golden.txt */
# Columns: step pattern hold fullness energy fun mood asleep
# Pattern bits from 0 up: sleep awake feed play test; hold 0 means bounce only
# Expected values include the decay tick on the boundary that starts each step
#
# Bounce shorter than the debounce window, then clean presses
glitchFeed 00100 0 4 4 4 Neutral 0
feed 00100 8 5 3 3 Neutral 0
play 01000 8 4 1 4 Tired 0
#
# Asleep, feed and play ignored, test raises energy
sleep 00001 8 3 0 3 Sleeping 1
feedAsleep 00100 8 2 1 2 Sleeping 1
playAsleep 01000 8 1 2 1 Sleeping 1
testAsleep 10000 8 0 4 0 Sleeping 1
#
# Awake again, normal mood priority
awake 00010 8 0 5 0 Hungry 0
feedHungry 00100 8 2 4 0 Hungry 0
feedBored 00100 8 3 3 0 Bored 0
feedPlay 01100 8 4 1 2 Tired 0
feedA 00100 8 5 0 1 Tired 0
feedB 00100 8 6 0 0 Tired 0
feedC 00100 8 7 0 0 Tired 0
#
# Fullness saturates at 7
feedSat 00100 8 7 0 0 Tired 0
testAwake 10000 8 5 0 0 Tired 0
#
# All five buttons on one edge
allFive 11111 8 5 0 1 Tired 0
#
# Idle for 2.5 tick periods
decay 00000 7500 2 0 0 Hungry 0

/* src.f */
common/petPkg.sv
verilog/buttonConditioner.sv
verilog/eventQueue.sv
petCore/petCore.sv
verilog/moodDisplay.sv
verilog/tamagotchi.sv
tb/tamagotchiTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
simBin=tamagotchiSim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tamagotchiTb \
    -f src.f \
    -Mdir "$buildDir" \
    -o "$simBin"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$buildDir/$simBin" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$logFile"; then
    echo "Simulation reported failure, see $logFile"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tb/tamagotchiTb.sv */
//////////////////////////////////////////////////////////////////////
// Virtual pet testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tamagotchiTb;

    localparam int debounceCycles = 4;
    localparam int queueDepth     = 4;
    localparam int tickCycles     = 3000;
    localparam int clkPeriod      = 40;
    localparam int maxSteps       = 64;
    // Happy needs every level at least this high
    localparam int happyMin       = 5;

    logic              clk;
    logic              arstN;
    logic [4:0]        buttons;
    petPkg::petStats_t stats;
    petPkg::mood_e     mood;
    logic              asleep;
    logic              overflow;
    logic [6:0]        sseg;
    logic [3:0]        an;

    // Golden step table
    string      stepName [maxSteps];
    logic [4:0] stepPattern [maxSteps];
    int         stepHold [maxSteps];
    int         expFull [maxSteps];
    int         expEnergy [maxSteps];
    int         expFun [maxSteps];
    int         expMood [maxSteps];
    int         expAsleep [maxSteps];
    int         stepCount;
    logic       goldenLoaded;

    int          cycleCount;
    int          overflowPulses;
    int          passCount;
    int          failCount;
    logic [31:0] rngState;

    tamagotchi #(
        .debounceCycles (debounceCycles),
        .queueDepth     (queueDepth),
        .tickCycles     (tickCycles)
    ) tamagotchi_i (
        .clk      (clk),
        .arstN    (arstN),
        .buttons  (buttons),
        .stats    (stats),
        .mood     (mood),
        .asleep   (asleep),
        .overflow (overflow),
        .sseg     (sseg),
        .an       (an)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Posedges since reset release, a decay tick lands on each multiple of tickCycles
    always @(posedge clk) begin
        if (arstN) cycleCount <= cycleCount + 1;
        if (arstN && overflow) overflowPulses <= overflowPulses + 1;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mood rules, first match wins
    function automatic int ruleMood(input int f, input int e, input int u, input int a);
        if (a != 0) return int'(petPkg::moodSleeping);
        if (f <= 2) return int'(petPkg::moodHungry);
        if (e <= 2) return int'(petPkg::moodTired);
        if (u <= 2) return int'(petPkg::moodBored);
        if (f >= happyMin && e >= happyMin && u >= happyMin) return int'(petPkg::moodHappy);
        return int'(petPkg::moodNeutral);
    endfunction

    // Active low, segment a on bit 6 down to g on bit 0
    function automatic logic [6:0] segFor(input int m);
        case (m)
            int'(petPkg::moodHappy):    return 7'b1001000;
            int'(petPkg::moodNeutral):  return 7'b1101010;
            int'(petPkg::moodHungry):   return 7'b1000001;
            int'(petPkg::moodTired):    return 7'b1110000;
            int'(petPkg::moodBored):    return 7'b1100000;
            int'(petPkg::moodSleeping): return 7'b0100100;
            default:                    return 7'b1111111;
        endcase
    endfunction

    function automatic int moodFromName(input logic [8*12-1:0] nm);
        if (nm == "Happy")    return int'(petPkg::moodHappy);
        if (nm == "Neutral")  return int'(petPkg::moodNeutral);
        if (nm == "Hungry")   return int'(petPkg::moodHungry);
        if (nm == "Tired")    return int'(petPkg::moodTired);
        if (nm == "Bored")    return int'(petPkg::moodBored);
        if (nm == "Sleeping") return int'(petPkg::moodSleeping);
        return -1;
    endfunction

    task automatic loadGolden();
        int               fd;
        int               code;
        int               m;
        string            line;
        logic [8*16-1:0]  nameBuf;
        logic [8*12-1:0]  moodBuf;
        logic [4:0]       pat;
        int               hold;
        int               f;
        int               e;
        int               u;
        int               a;
        fd = $fopen("tb/tamagotchi_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/tamagotchi_golden.txt");
            failCount++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Skip blank and comment lines
            if (code == 0 || line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%s %b %d %d %d %d %s %d",
                           nameBuf, pat, hold, f, e, u, moodBuf, a);
            m = moodFromName(moodBuf);
            if (code != 8 || m < 0 || stepCount == maxSteps) begin
                $display("Golden file line could not be read: %s", line);
                failCount++;
                continue;
            end
            if (f > petPkg::levelMax || e > petPkg::levelMax || u > petPkg::levelMax ||
                m != ruleMood(f, e, u, a)) begin
                $display("Golden file row disagrees with the level and mood rules: %s", line);
                failCount++;
            end
            stepName[stepCount]    = string'(nameBuf);
            stepPattern[stepCount] = pat;
            stepHold[stepCount]    = hold;
            expFull[stepCount]     = f;
            expEnergy[stepCount]   = e;
            expFun[stepCount]      = u;
            expMood[stepCount]     = m;
            expAsleep[stepCount]   = a;
            stepCount++;
        end
        $fclose(fd);
        if (stepCount == 0) begin
            $display("The golden file holds no steps");
            failCount++;
        end
    endtask

    task automatic checkOutputs(input string name, input int ef, input int ee,
                                input int eu, input int em, input int ea);
        int errs;
        errs = 0;
        if (stats.fullness != 3'(ef)) begin
            $display("Mismatch at %0t ns: %s fullness %0d, expected %0d",
                     $time, name, stats.fullness, ef);
            errs++;
        end
        if (stats.energy != 3'(ee)) begin
            $display("Mismatch at %0t ns: %s energy %0d, expected %0d",
                     $time, name, stats.energy, ee);
            errs++;
        end
        if (stats.fun != 3'(eu)) begin
            $display("Mismatch at %0t ns: %s fun %0d, expected %0d", $time, name, stats.fun, eu);
            errs++;
        end
        if (mood != petPkg::mood_e'(em)) begin
            $display("Mismatch at %0t ns: %s mood %0d, expected %0d", $time, name, mood, em);
            errs++;
        end
        if (asleep != 1'(ea)) begin
            $display("Mismatch at %0t ns: %s asleep %0d, expected %0d", $time, name, asleep, ea);
            errs++;
        end
        // Display lags mood by a cycle, long settled here
        if (sseg != segFor(em) || an != 4'b1110) begin
            $display("Mismatch at %0t ns: %s sseg %b an %b, expected %b and 1110",
                     $time, name, sseg, an, segFor(em));
            errs++;
        end
        // Queue never fills while the core drains one event per cycle
        if (overflowPulses != 0) begin
            $display("Mismatch at %0t ns: %s overflow pulsed %0d times, expected none",
                     $time, name, overflowPulses);
            errs++;
        end
        if (errs == 0) begin
            passCount++;
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: %0d wrong outputs", name, errs);
        end
    endtask

    task automatic waitTickBoundary();
        do @(negedge clk); while (cycleCount % tickCycles != 0);
    endtask

    // Bounce first, then the clean hold, then let the events drain
    task automatic runStep(input int idx);
        int glitchLen;
        waitTickBoundary();
        if (stepPattern[idx] != 5'b00000) begin
            for (int g = 0; g < 2; g++) begin
                rngState  = lcgNext(rngState);
                glitchLen = 1 + int'(rngState[23:16]) % (debounceCycles - 1);
                buttons   = stepPattern[idx];
                repeat (glitchLen) @(negedge clk);
                buttons   = 5'b00000;
                repeat (2) @(negedge clk);
            end
        end
        if (stepHold[idx] > 0) begin
            buttons = stepPattern[idx];
            repeat (stepHold[idx]) @(negedge clk);
            buttons = 5'b00000;
        end
        repeat (debounceCycles + 10) @(negedge clk);
        checkOutputs(stepName[idx], expFull[idx], expEnergy[idx], expFun[idx],
                     expMood[idx], expAsleep[idx]);
    endtask

    initial begin
        clk            = 1'b0;
        arstN          = 1'b0;
        buttons        = 5'b00000;
        cycleCount     = 0;
        overflowPulses = 0;
        passCount      = 0;
        failCount      = 0;
        stepCount      = 0;
        goldenLoaded   = 1'b0;
        rngState       = 32'hf1586b68;
        loadGolden();
        goldenLoaded = 1'b1;
        repeat (3) @(negedge clk);
        // Reset values, seen while arstN is still low
        checkOutputs("reset", 5, 5, 5, int'(petPkg::moodHappy), 0);
        arstN = 1'b1;
        for (int i = 0; i < stepCount; i++) begin
            runStep(i);
        end
        $display("Summary: %0d passed, %0d failed, %0d overflow pulses seen",
                 passCount, failCount, overflowPulses);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog, one tick period per step plus a margin
    initial begin
        longint limitNs;
        wait (goldenLoaded);
        limitNs = longint'(stepCount + 4) * tickCycles * clkPeriod;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("Test failed");
        $finish;
    end

endmodule

/* verilog/tamagotchi.sv */
//////////////////////////////////////////////////////////////////////
// Virtual pet top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tamagotchi #(
    parameter int debounceCycles = 4,
    parameter int queueDepth     = 4,
    parameter int tickCycles     = 3000
) (
    input  logic              clk,
    input  logic              arstN,
    // Sleep, awake, feed, play, test from bit 0 up
    input  logic [4:0]        buttons,
    output petPkg::petStats_t stats,
    output petPkg::mood_e     mood,
    output logic              asleep,
    output logic              overflow,
    output logic [6:0]        sseg,
    output logic [3:0]        an
);

    petPkg::petEvt_t evt;
    petPkg::petEvt_t head;
    logic            pop;

    // Producer
    buttonConditioner #(.debounceCycles(debounceCycles)) conditioner_i (
        .clk     (clk),
        .arstN   (arstN),
        .buttons (buttons),
        .evt     (evt)
    );

    // Buffer, drops on full
    eventQueue #(.queueDepth(queueDepth)) queue_i (
        .clk      (clk),
        .arstN    (arstN),
        .evt      (evt),
        .pop      (pop),
        .head     (head),
        .overflow (overflow)
    );

    // Consumer
    petCore #(.tickCycles(tickCycles)) core_i (
        .clk    (clk),
        .arstN  (arstN),
        .head   (head),
        .pop    (pop),
        .stats  (stats),
        .mood   (mood),
        .asleep (asleep)
    );

    moodDisplay display_i (
        .clk   (clk),
        .arstN (arstN),
        .mood  (mood),
        .sseg  (sseg),
        .an    (an)
    );

endmodule

/* verilog/moodDisplay.sv */
//////////////////////////////////////////////////////////////////////
// Mood to seven-segment
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module moodDisplay (
    input  logic          clk,
    input  logic          arstN,
    input  petPkg::mood_e mood,
    output logic [6:0]    sseg,
    output logic [3:0]    an
);

    // Segment order a..g from bit 6 down, active low
    localparam logic [6:0] segH     = 7'b1001000;
    localparam logic [6:0] segN     = 7'b1101010;
    localparam logic [6:0] segU     = 7'b1000001;
    localparam logic [6:0] segT     = 7'b1110000;
    localparam logic [6:0] segB     = 7'b1100000;
    localparam logic [6:0] segS     = 7'b0100100;
    localparam logic [6:0] segBlank = 7'b1111111;

    logic [6:0] segNext;

    always_comb begin
        case (mood)
            petPkg::moodHappy:    segNext = segH;
            petPkg::moodNeutral:  segNext = segN;
            petPkg::moodHungry:   segNext = segU;
            petPkg::moodTired:    segNext = segT;
            petPkg::moodBored:    segNext = segB;
            petPkg::moodSleeping: segNext = segS;
            default:              segNext = segBlank;
        endcase
    end

    // Only digit 0 enabled, from reset on
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sseg <= segH;
            an   <= 4'b1110;
        end else begin
            sseg <= segNext;
            an   <= 4'b1110;
        end
    end

endmodule

/* petCore/petCore.sv */
//////////////////////////////////////////////////////////////////////
// Pet controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module petCore #(
    parameter int tickCycles = 3000
) (
    input  logic              clk,
    input  logic              arstN,
    input  petPkg::petEvt_t   head,
    output logic              pop,
    output petPkg::petStats_t stats,
    output petPkg::mood_e     mood,
    output logic              asleep
);

    localparam int tickW = $clog2(tickCycles);

    logic [tickW-1:0]   tickCnt;
    logic               tickDue;
    logic               doTick;
    petPkg::petState_e  state;
    petPkg::petState_e  stateNext;
    petPkg::petStats_t  statsNext;

    // Saturating level add
    function automatic logic [2:0] satAdd(input logic [2:0] lvl, input logic [2:0] amt);
        logic [3:0] sum;
        sum = {1'b0, lvl} + {1'b0, amt};
        return (sum > {1'b0, petPkg::levelMax}) ? petPkg::levelMax : sum[2:0];
    endfunction

    // Saturating level subtract, floor at zero
    function automatic logic [2:0] satSub(input logic [2:0] lvl, input logic [2:0] amt);
        return (lvl >= amt) ? (lvl - amt) : 3'd0;
    endfunction

    // Mood priority, first match wins
    function automatic petPkg::mood_e pickMood(input petPkg::petStats_t s,
                                               input petPkg::petState_e st);
        if (st == petPkg::stAsleep)               return petPkg::moodSleeping;
        if (s.fullness <= petPkg::lowLevel)       return petPkg::moodHungry;
        if (s.energy <= petPkg::lowLevel)         return petPkg::moodTired;
        if (s.fun <= petPkg::lowLevel)            return petPkg::moodBored;
        if (s.fullness >= petPkg::levelInit && s.energy >= petPkg::levelInit &&
            s.fun >= petPkg::levelInit)           return petPkg::moodHappy;
        return petPkg::moodNeutral;
    endfunction

    // Decay timer, free running from reset release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tickCnt <= '0;
        end else if (tickDue) begin
            tickCnt <= '0;
        end else begin
            tickCnt <= tickCnt + 1'b1;
        end
    end

    assign tickDue = (tickCnt == tickW'(tickCycles - 1));

    // Tick wins, the event waits in the queue
    assign pop    = head.valid && !tickDue;
    // Test press is one tick now, timer untouched
    assign doTick = tickDue || (pop && head.kind == petPkg::evTest);

    always_comb begin
        statsNext = stats;
        stateNext = state;
        if (doTick) begin
            statsNext.fullness = satSub(stats.fullness, 3'd1);
            statsNext.fun      = satSub(stats.fun, 3'd1);
            // Sleep restores energy
            if (state == petPkg::stAsleep) begin
                statsNext.energy = satAdd(stats.energy, 3'd1);
            end else begin
                statsNext.energy = satSub(stats.energy, 3'd1);
            end
        end else if (pop) begin
            case (head.kind)
                petPkg::evSleep: stateNext = petPkg::stAsleep;
                petPkg::evAwake: stateNext = petPkg::stAwake;
                petPkg::evFeed: begin
                    // Ignored while asleep
                    if (state == petPkg::stAwake) begin
                        statsNext.fullness = satAdd(stats.fullness, 3'd2);
                    end
                end
                petPkg::evPlay: begin
                    if (state == petPkg::stAwake) begin
                        statsNext.fun    = satAdd(stats.fun, 3'd2);
                        statsNext.energy = satSub(stats.energy, 3'd1);
                    end
                end
                default: statsNext = stats;
            endcase
        end
    end

    // Mood registered from the next levels, so it moves with stats
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= petPkg::stAwake;
            stats <= '{fullness: petPkg::levelInit,
                       energy:   petPkg::levelInit,
                       fun:      petPkg::levelInit};
            mood  <= petPkg::moodHappy;
        end else begin
            state <= stateNext;
            stats <= statsNext;
            mood  <= pickMood(statsNext, stateNext);
        end
    end

    assign asleep = (state == petPkg::stAsleep);

    // Up by 2 at most, down by 1 at most
    function automatic logic stepOk(input logic [2:0] now, input logic [2:0] was);
        return ({1'b0, now} <= {1'b0, was} + 4'd2) && ({1'b0, now} + 4'd1 >= {1'b0, was});
    endfunction

    // Levels saturate instead of wrapping past 7 or below 0
    assert property (@(posedge clk) disable iff (!arstN)
        stepOk(stats.fullness, $past(stats.fullness)) &&
        stepOk(stats.energy, $past(stats.energy)) &&
        stepOk(stats.fun, $past(stats.fun)));

endmodule

/* verilog/eventQueue.sv */
//////////////////////////////////////////////////////////////////////
// Pending event FIFO
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module eventQueue #(
    parameter int queueDepth = 4
) (
    input  logic            clk,
    input  logic            arstN,
    input  petPkg::petEvt_t evt,
    input  logic            pop,
    output petPkg::petEvt_t head,
    output logic            overflow
);

    localparam int ptrW = $clog2(queueDepth);

    // Storage holds only the kind, valid comes from the count
    petPkg::petEvent_e mem [queueDepth];

    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   count;
    logic            full;
    logic            push;
    logic            doPop;

    assign full  = (count == (ptrW + 1)'(queueDepth));
    // Full queue drops the incoming event
    assign push  = evt.valid && !full;
    assign doPop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= evt.kind;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Pointers wrap on power-of-two depth
            if (push)  wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Single-cycle drop flag
            overflow <= evt.valid && full;
        end
    end

    assign head = '{valid: (count != '0), kind: mem[rdPtr]};

    assert property (@(posedge clk) disable iff (!arstN) pop |-> count != '0);

    assert property (@(posedge clk) disable iff (!arstN)
        count <= (ptrW + 1)'(queueDepth));

endmodule

/* verilog/buttonConditioner.sv */
//////////////////////////////////////////////////////////////////////
// Button sync, debounce and event strobes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module buttonConditioner #(
    parameter int debounceCycles = 4
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic [4:0]      buttons,
    output petPkg::petEvt_t evt
);

    localparam int cntW = $clog2(debounceCycles + 1);

    logic [4:0]      syncA;
    logic [4:0]      syncB;
    logic [4:0]      dbLevel;
    logic [4:0]      dbLast;
    logic [4:0]      pending;
    logic [4:0]      req;
    logic [4:0]      grant;
    logic [2:0]      grantIdx;
    logic [cntW-1:0] stableCnt [5];

    // Two-flop synchronizer
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= buttons;
            syncB <= syncA;
        end
    end

    // Per-button stability counter
    // Level taken once it differs for debounceCycles cycles in a row
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 5; i++) begin
                stableCnt[i] <= '0;
            end
            dbLevel <= '0;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (syncB[i] == dbLevel[i]) begin
                    stableCnt[i] <= '0;
                end else if (stableCnt[i] == cntW'(debounceCycles - 1)) begin
                    dbLevel[i]   <= syncB[i];
                    stableCnt[i] <= '0;
                end else begin
                    stableCnt[i] <= stableCnt[i] + 1'b1;
                end
            end
        end
    end

    // Fresh rising edges plus presses still waiting
    assign req = pending | (dbLevel & ~dbLast);

    // Lowest index wins
    always_comb begin
        grantIdx = '0;
        for (int i = 4; i >= 0; i--) begin
            if (req[i]) grantIdx = 3'(i);
        end
    end

    assign grant = (|req) ? (5'b00001 << grantIdx) : 5'b00000;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dbLast    <= '0;
            pending   <= '0;
            evt.valid <= 1'b0;
            evt.kind  <= petPkg::evSleep;
        end else begin
            dbLast    <= dbLevel;
            // Losers wait for a later cycle
            pending   <= req & ~grant;
            evt.valid <= |req;
            evt.kind  <= petPkg::petEvent_e'(grantIdx);
        end
    end

    // One strobe per press, never repeated back to back
    assert property (@(posedge clk) disable iff (!arstN)
        evt.valid |=> !(evt.valid && evt.kind == $past(evt.kind)));

endmodule

/* common/petPkg.sv */
//////////////////////////////////////////////////////////////////////
// Virtual pet shared types
//////////////////////////////////////////////////////////////////////
package petPkg;

    // Event kinds, one per button
    // Values follow the button vector index
    typedef enum logic [2:0] {
        evSleep = 3'd0,
        evAwake = 3'd1,
        evFeed  = 3'd2,
        evPlay  = 3'd3,
        evTest  = 3'd4
    } petEvent_e;

    // Event word from conditioner through queue to core
    typedef struct packed {
        logic      valid;
        petEvent_e kind;
    } petEvt_t;

    // Mood shown on the display
    typedef enum logic [2:0] {
        moodHappy    = 3'd0,
        moodNeutral  = 3'd1,
        moodHungry   = 3'd2,
        moodTired    = 3'd3,
        moodBored    = 3'd4,
        moodSleeping = 3'd5
    } mood_e;

    // Core sleep state
    typedef enum logic {
        stAwake  = 1'b0,
        stAsleep = 1'b1
    } petState_e;

    // Pet levels, 0 to 7 each
    typedef struct packed {
        logic [2:0] fullness;
        logic [2:0] energy;
        logic [2:0] fun;
    } petStats_t;

    // Saturation limit of every level
    localparam logic [2:0] levelMax = 3'd7;

    // Value of each level after reset
    localparam logic [2:0] levelInit = 3'd5;

    // At or below this a level counts as low
    localparam logic [2:0] lowLevel = 3'd2;

endpackage
